// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_compute_tile
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG ?= Simulation finished: FAIL
PASS_MSG ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "test did not finish"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_compute_tile.sv ====
// Testbench for the compute tile: random programs, reference model and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tb_compute_tile;

   localparam int pc_w = 8;
   localparam int depth = 2**pc_w;
   localparam int xlen = tile_pkg::insn_w;
   localparam int num_progs = 6;
   localparam int halt_limit = 2000;

   logic clk;
   logic rst_n;
   logic run;
   logic imem_we;
   logic [pc_w-1:0] imem_addr;
   logic [xlen-1:0] imem_wdata;
   wire trace_valid;
   wire [pc_w-1:0] trace_pc;
   wire [xlen-1:0] trace_insn;
   wire trace_wb_en;
   wire [tile_pkg::reg_addr_w-1:0] trace_wb_reg;
   wire [xlen-1:0] trace_wb_data;
   wire report_valid;
   wire [xlen-1:0] report_data;
   wire putc_valid;
   wire [7:0] putc_char;
   wire halted;

   // Stimulus state
   logic [31:0] lfsr_state;
   logic started;
   logic [xlen-1:0] prog [depth];
   int mismatches = 0;
   int timeouts = 0;
   int retired = 0;
   int reports = 0;
   int putcs = 0;

   // Reference model state and its view of the next entry
   logic [pc_w-1:0] m_pc;
   logic [xlen-1:0] m_regs [tile_pkg::reg_num];
   logic [xlen-1:0] m_r3;
   logic [xlen-1:0] exp_insn;
   logic [tile_pkg::op_w-1:0] exp_op;
   logic [tile_pkg::reg_addr_w-1:0] exp_rd;
   logic [tile_pkg::imm_w-1:0] exp_imm;
   logic [xlen-1:0] rs_v;
   logic [xlen-1:0] rt_v;
   logic [xlen-1:0] imm_sx;
   logic exp_wb_en;
   logic [xlen-1:0] exp_wb_data;
   logic [pc_w-1:0] exp_next_pc;

   // Nop entries seen on the trace
   logic tr_nop;
   logic tr_report;
   logic tr_putc;
   logic tr_exit;

   compute_tile #(.pc_w(pc_w)) i_compute_tile (.*);

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic lsb;
      val = '0;
      for (int i = 0; i < n; i++) begin
         lsb = lfsr_state[0];
         lfsr_state = lfsr_state >> 1;
         if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
         end
         val = {val[30:0], lsb};
      end
      return val;
   endfunction

   function automatic logic [xlen-1:0] encode(
      input logic [tile_pkg::op_w-1:0] op,
      input logic [tile_pkg::reg_addr_w-1:0] rd,
      input logic [tile_pkg::reg_addr_w-1:0] rs,
      input logic [tile_pkg::reg_addr_w-1:0] rt,
      input logic [tile_pkg::imm_w-1:0] imm
   );
      logic [xlen-1:0] w;
      w = '0;
      w[tile_pkg::op_lsb +: tile_pkg::op_w] = op;
      w[tile_pkg::rd_lsb +: tile_pkg::reg_addr_w] = rd;
      w[tile_pkg::rs_lsb +: tile_pkg::reg_addr_w] = rs;
      w[tile_pkg::rt_lsb +: tile_pkg::reg_addr_w] = rt;
      w[tile_pkg::imm_lsb +: tile_pkg::imm_w] = imm;
      return w;
   endfunction

   task automatic flag_mismatch(input string msg);
      mismatches++;
      $display("Mismatch at %0t: %s", $time, msg);
   endtask

   // Registers r0..r3 only, so results get reused a lot
   task automatic build_program(input int len);
      int a;
      int room;
      logic [3:0] kind;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [15:0] imm;
      logic [15:0] offset;
      // Filler is addi into r0, immediate tied to the address
      for (a = 0; a < depth; a++) begin
         prog[pc_w'(a)] = encode(tile_pkg::op_addi, 3'd0, 3'd0, 3'd0, 16'(a) ^ 16'h5a00);
      end
      for (a = 0; a < len - 3; a++) begin
         kind = 4'(rand_bits(4));
         rd = 3'(rand_bits(2));
         rs = 3'(rand_bits(2));
         rt = 3'(rand_bits(2));
         imm = 16'(rand_bits(16));
         case (kind)
            4'd0, 4'd1: prog[pc_w'(a)] = encode(tile_pkg::op_add, rd, rs, rt, imm);
            4'd2: prog[pc_w'(a)] = encode(tile_pkg::op_sub, rd, rs, rt, imm);
            4'd3: prog[pc_w'(a)] = encode(tile_pkg::op_xor, rd, rs, rt, imm);
            4'd4, 4'd5, 4'd6: prog[pc_w'(a)] = encode(tile_pkg::op_addi, rd, rs, rt, imm);
            4'd7, 4'd8: prog[pc_w'(a)] = encode(tile_pkg::op_lui, rd, rs, rt, imm);
            4'd9, 4'd10: begin
               // Forward only, at most as far as the exit nop
               room = len - 2 - a;
               offset = 16'(rand_bits(2));
               if (int'(offset) > room) begin
                  offset = 16'(room);
               end
               prog[pc_w'(a)] = encode(tile_pkg::op_bnez, 3'd0, rs, 3'd0, offset);
            end
            4'd11: prog[pc_w'(a)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0,
                                           tile_pkg::nop_report);
            4'd12: prog[pc_w'(a)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0,
                                           tile_pkg::nop_putc);
            4'd13: prog[pc_w'(a)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0, 16'd0);
            // Keep r3 moving for the monitor
            4'd14: prog[pc_w'(a)] = encode(tile_pkg::op_add, tile_pkg::report_reg,
                                           rs, rt, imm);
            default: prog[pc_w'(a)] = encode(tile_pkg::op_addi, tile_pkg::report_reg,
                                             rs, rt, imm);
         endcase
      end
      prog[pc_w'(len - 3)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0, tile_pkg::nop_report);
      prog[pc_w'(len - 2)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0, tile_pkg::nop_putc);
      prog[pc_w'(len - 1)] = encode(tile_pkg::op_nop, 3'd0, 3'd0, 3'd0, tile_pkg::nop_exit);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      run = 1'b0;
      started = 1'b0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
   endtask

   // Whole memory written while run is low
   task automatic load_program();
      int a;
      for (a = 0; a < depth; a++) begin
         @(negedge clk);
         imem_we = 1'b1;
         imem_addr = pc_w'(a);
         imem_wdata = prog[pc_w'(a)];
      end
      @(negedge clk);
      imem_we = 1'b0;
   endtask

   task automatic run_program(input int idx);
      int cycles;
      cycles = 0;
      @(negedge clk);
      started = 1'b1;
      run = 1'b1;
      // About one cycle in eight with run low
      while (!halted && cycles < halt_limit) begin
         @(negedge clk);
         run = (rand_bits(3) != 0);
         cycles++;
      end
      if (!halted) begin
         timeouts++;
         $display("Program %0d: the tile never halted within %0d cycles", idx, halt_limit);
      end
      // Quiet trace after the exit
      run = 1'b1;
      repeat (8) @(negedge clk);
   endtask

   initial begin
      int p;
      rst_n = 1'b0;
      run = 1'b0;
      imem_we = 1'b0;
      imem_addr = '0;
      imem_wdata = '0;
      started = 1'b0;
      lfsr_state = 32'h5434;
      for (p = 0; p < num_progs; p++) begin
         apply_reset();
         build_program(16 + int'(rand_bits(5)));
         load_program();
         run_program(p);
      end
      $display("Programs %0d, retired %0d, reports %0d, putc %0d, mismatches %0d, timeouts %0d",
               num_progs, retired, reports, putcs, mismatches, timeouts);
      if (mismatches == 0 && timeouts == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   // ISA rules applied to the word at the expected pc
   assign m_r3 = m_regs[tile_pkg::report_reg];

   always_comb begin
      exp_insn = prog[m_pc];
      exp_op = exp_insn[tile_pkg::op_lsb +: tile_pkg::op_w];
      exp_rd = exp_insn[tile_pkg::rd_lsb +: tile_pkg::reg_addr_w];
      exp_imm = exp_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w];
      rs_v = m_regs[exp_insn[tile_pkg::rs_lsb +: tile_pkg::reg_addr_w]];
      rt_v = m_regs[exp_insn[tile_pkg::rt_lsb +: tile_pkg::reg_addr_w]];
      imm_sx = {{(xlen - tile_pkg::imm_w){exp_imm[tile_pkg::imm_w-1]}}, exp_imm};
      exp_wb_en = 1'b1;
      exp_wb_data = '0;
      exp_next_pc = m_pc + 1'b1;
      case (exp_op)
         tile_pkg::op_add:  exp_wb_data = rs_v + rt_v;
         tile_pkg::op_sub:  exp_wb_data = rs_v - rt_v;
         tile_pkg::op_xor:  exp_wb_data = rs_v ^ rt_v;
         tile_pkg::op_addi: exp_wb_data = rs_v + imm_sx;
         tile_pkg::op_lui:  exp_wb_data = {exp_imm, {(xlen - tile_pkg::imm_w){1'b0}}};
         tile_pkg::op_bnez: begin
            exp_wb_en = 1'b0;
            // Offset in words from pc plus one
            if (rs_v != '0) begin
               exp_next_pc = m_pc + 1'b1 + exp_imm[pc_w-1:0];
            end
         end
         default: exp_wb_en = 1'b0;
      endcase
      if (exp_rd == '0) begin
         exp_wb_en = 1'b0;
      end
   end

   // Model steps once per trace entry
   always @(posedge clk) begin
      if (!rst_n) begin
         m_pc <= '0;
         for (int i = 0; i < tile_pkg::reg_num; i++) begin
            m_regs[tile_pkg::reg_addr_w'(i)] <= '0;
         end
      end else if (trace_valid) begin
         m_pc <= exp_next_pc;
         if (exp_wb_en) begin
            m_regs[exp_rd] <= exp_wb_data;
         end
         retired <= retired + 1;
      end
   end

   always @(posedge clk) begin
      if (rst_n && report_valid) begin
         reports <= reports + 1;
      end
      if (rst_n && putc_valid) begin
         putcs <= putcs + 1;
      end
   end

   assign tr_nop = trace_valid &&
                   trace_insn[tile_pkg::op_lsb +: tile_pkg::op_w] == tile_pkg::op_nop;
   assign tr_report = tr_nop &&
                      trace_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w] == tile_pkg::nop_report;
   assign tr_putc = tr_nop &&
                    trace_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w] == tile_pkg::nop_putc;
   assign tr_exit = tr_nop &&
                    trace_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w] == tile_pkg::nop_exit;

   // Program order, taken branches and flushed work
   a_pc_order: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid |-> trace_pc == m_pc)
      else flag_mismatch("trace pc is not the next pc in program order");

   a_insn_word: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid |-> trace_insn == exp_insn)
      else flag_mismatch("trace instruction differs from the program word");

   // Results, including forwarded operands and r0 destinations
   a_wb_enable: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid |-> trace_wb_en == exp_wb_en)
      else flag_mismatch("trace writeback enable differs from the model");

   a_wb_value: assert property (@(posedge clk) disable iff (!rst_n)
      trace_valid && exp_wb_en |-> trace_wb_reg == exp_rd && trace_wb_data == exp_wb_data)
      else flag_mismatch("trace writeback register or data differs from the model");

   // Report and putc strobes
   a_report_follows: assert property (@(posedge clk) disable iff (!rst_n)
      tr_report |=> report_valid)
      else flag_mismatch("no report strobe after a report nop");

   a_report_source: assert property (@(posedge clk) disable iff (!rst_n)
      report_valid |-> $past(tr_report))
      else flag_mismatch("report strobe without a report nop");

   a_report_data: assert property (@(posedge clk) disable iff (!rst_n)
      report_valid |-> report_data == $past(m_r3))
      else flag_mismatch("report data is not the model r3");

   a_putc_follows: assert property (@(posedge clk) disable iff (!rst_n)
      tr_putc |=> putc_valid)
      else flag_mismatch("no putc strobe after a putc nop");

   a_putc_source: assert property (@(posedge clk) disable iff (!rst_n)
      putc_valid |-> $past(tr_putc))
      else flag_mismatch("putc strobe without a putc nop");

   a_putc_char: assert property (@(posedge clk) disable iff (!rst_n)
      putc_valid |-> putc_char == $past(m_r3[7:0]))
      else flag_mismatch("putc character is not the low byte of the model r3");

   // Exit and halt
   a_halt_follows: assert property (@(posedge clk) disable iff (!rst_n)
      tr_exit |=> halted)
      else flag_mismatch("halted did not rise after the exit nop");

   a_halt_source: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(halted) |-> $past(tr_exit))
      else flag_mismatch("halted rose without an exit nop");

   a_quiet_halted: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> !trace_valid)
      else flag_mismatch("trace entry after the exit nop");

   a_halt_held: assert property (@(posedge clk) disable iff (!rst_n)
      halted |=> halted)
      else flag_mismatch("halted dropped before reset");

   // Reset state and idle before start
   a_reset_clear: assert property (@(posedge clk)
      $rose(rst_n) |-> !trace_valid && !report_valid && !putc_valid && !halted)
      else flag_mismatch("strobe or halted high right after reset");

   a_idle_before_run: assert property (@(posedge clk) disable iff (!rst_n)
      !started |-> !trace_valid)
      else flag_mismatch("trace entry before run was raised");

endmodule

`default_nettype wire

// ==== files.f ====
src/tile_pkg.sv
src/insn_mem.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/run_monitor.sv
src/compute_tile.sv
dv/tb_compute_tile.sv

// ==== src/compute_tile.sv ====
// Compute tile top with instruction memory, three pipeline stages and run monitor
`timescale 1ns/1ps
`default_nettype none

module compute_tile #(
   parameter int pc_w = 8
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                run,
   input  wire                                imem_we,
   input  wire [pc_w-1:0]                     imem_addr,
   input  wire [tile_pkg::insn_w-1:0]         imem_wdata,
   output wire                                trace_valid,
   output wire [pc_w-1:0]                     trace_pc,
   output wire [tile_pkg::insn_w-1:0]         trace_insn,
   output wire                                trace_wb_en,
   output wire [tile_pkg::reg_addr_w-1:0]     trace_wb_reg,
   output wire [tile_pkg::insn_w-1:0]         trace_wb_data,
   output wire                                report_valid,
   output wire [tile_pkg::insn_w-1:0]         report_data,
   output wire                                putc_valid,
   output wire [7:0]                          putc_char,
   output wire                                halted
);

   // Fetch
   wire [pc_w-1:0]                  fetch_addr;
   wire [tile_pkg::insn_w-1:0]      fetch_insn;

   // Decode to execute
   wire                             dec_valid;
   wire [pc_w-1:0]                  dec_pc;
   wire [tile_pkg::insn_w-1:0]      dec_insn;
   wire tile_pkg::opcode_e          dec_op;
   wire [tile_pkg::reg_addr_w-1:0]  dec_rd;
   wire [tile_pkg::insn_w-1:0]      dec_rs_val;
   wire [tile_pkg::insn_w-1:0]      dec_rt_val;
   wire [tile_pkg::imm_w-1:0]       dec_imm;

   // Execute to result, also forwarded back to decode
   wire                             ex_valid;
   wire [pc_w-1:0]                  ex_pc;
   wire [tile_pkg::insn_w-1:0]      ex_insn;
   wire                             ex_wb_en;
   wire [tile_pkg::reg_addr_w-1:0]  ex_rd;
   wire [tile_pkg::insn_w-1:0]      ex_value;

   // Redirect and kill
   wire                             branch_taken;
   wire [pc_w-1:0]                  branch_target;
   wire                             halt_flush;

   // Register file write
   wire                             wb_en;
   wire [tile_pkg::reg_addr_w-1:0]  wb_reg;
   wire [tile_pkg::insn_w-1:0]      wb_data;

   insn_mem #(.pc_w(pc_w)) i_insn_mem (.*);

   decode_stage #(.pc_w(pc_w)) i_decode_stage (.*);

   execute_stage #(.pc_w(pc_w)) i_execute_stage (.*);

   result_stage #(.pc_w(pc_w)) i_result_stage (.*);

   run_monitor i_run_monitor (.*);

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
// Program counter, fetch tracking, field decode, register file and operand forwarding
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
   parameter int pc_w = 8
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                run,
   input  wire                                halted,
   input  wire [tile_pkg::insn_w-1:0]         fetch_insn,
   input  wire                                branch_taken,
   input  wire [pc_w-1:0]                     branch_target,
   input  wire                                ex_wb_en,
   input  wire [tile_pkg::reg_addr_w-1:0]     ex_rd,
   input  wire [tile_pkg::insn_w-1:0]         ex_value,
   input  wire                                wb_en,
   input  wire [tile_pkg::reg_addr_w-1:0]     wb_reg,
   input  wire [tile_pkg::insn_w-1:0]         wb_data,
   output logic [pc_w-1:0]                    fetch_addr,
   output logic                               dec_valid,
   output logic [pc_w-1:0]                    dec_pc,
   output logic [tile_pkg::insn_w-1:0]        dec_insn,
   output tile_pkg::opcode_e                  dec_op,
   output logic [tile_pkg::reg_addr_w-1:0]    dec_rd,
   output logic [tile_pkg::insn_w-1:0]        dec_rs_val,
   output logic [tile_pkg::insn_w-1:0]        dec_rt_val,
   output logic [tile_pkg::imm_w-1:0]         dec_imm
);

   logic [pc_w-1:0] pc;
   logic [pc_w-1:0] f_pc;
   logic f_valid;
   logic fetch;
   logic [tile_pkg::insn_w-1:0] regs [tile_pkg::reg_num];

   // Operand read, youngest pending result wins
   function automatic logic [tile_pkg::insn_w-1:0] operand(
      input logic [tile_pkg::reg_addr_w-1:0] idx
   );
      logic [tile_pkg::insn_w-1:0] val;
      if (idx == '0) begin
         val = '0;
      end else if (ex_wb_en && ex_rd == idx) begin
         val = ex_value;
      end else if (wb_en && wb_reg == idx) begin
         val = wb_data;
      end else begin
         val = regs[idx];
      end
      return val;
   endfunction

   // One fetch per cycle while running
   assign fetch = run && !halted;
   assign fetch_addr = pc;

   // Taken branch drops the word in memory read and the one being addressed
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pc <= '0;
         f_valid <= 1'b0;
         dec_valid <= 1'b0;
      end else begin
         if (branch_taken) begin
            pc <= branch_target;
         end else if (fetch) begin
            pc <= pc + 1'b1;
         end
         f_valid <= fetch && !branch_taken;
         dec_valid <= f_valid && !branch_taken && !halted;
      end
   end

   // Pc follows its word through the memory read
   always_ff @(posedge clk) begin
      f_pc <= pc;
      dec_pc <= f_pc;
      dec_insn <= fetch_insn;
   end

   // Register file, writes to r0 dropped
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < tile_pkg::reg_num; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_en && wb_reg != '0) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // Field split
   assign dec_op = tile_pkg::opcode_e'(dec_insn[tile_pkg::op_lsb +: tile_pkg::op_w]);
   assign dec_rd = dec_insn[tile_pkg::rd_lsb +: tile_pkg::reg_addr_w];
   assign dec_imm = dec_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w];

   // Operands resolved in the decode cycle itself
   always_comb begin
      dec_rs_val = operand(dec_insn[tile_pkg::rs_lsb +: tile_pkg::reg_addr_w]);
      dec_rt_val = operand(dec_insn[tile_pkg::rt_lsb +: tile_pkg::reg_addr_w]);
   end

   // No new item without a fetch issued two cycles earlier
   a_no_dec_without_run: assert property (@(posedge clk) disable iff (!rst_n)
      !$past(run, 1) && !$past(run, 2) |-> !dec_valid);

   a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
      regs[0] == '0);

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
// ALU, writeback enable, branch resolution and kill of younger decode work
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
   parameter int pc_w = 8
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                dec_valid,
   input  wire [pc_w-1:0]                     dec_pc,
   input  wire [tile_pkg::insn_w-1:0]         dec_insn,
   input  wire tile_pkg::opcode_e             dec_op,
   input  wire [tile_pkg::reg_addr_w-1:0]     dec_rd,
   input  wire [tile_pkg::insn_w-1:0]         dec_rs_val,
   input  wire [tile_pkg::insn_w-1:0]         dec_rt_val,
   input  wire [tile_pkg::imm_w-1:0]          dec_imm,
   input  wire                                halt_flush,
   output logic                               ex_valid,
   output logic [pc_w-1:0]                    ex_pc,
   output logic [tile_pkg::insn_w-1:0]        ex_insn,
   output logic                               ex_wb_en,
   output logic [tile_pkg::reg_addr_w-1:0]    ex_rd,
   output logic [tile_pkg::insn_w-1:0]        ex_value,
   output logic                               branch_taken,
   output logic [pc_w-1:0]                    branch_target
);

   logic v_q;
   logic wb_q;
   logic drop_q;
   logic live;
   logic alu_wb;
   logic [tile_pkg::insn_w-1:0] alu;
   logic [tile_pkg::insn_w-1:0] imm_sx;

   // Item survives a previous branch or exit
   assign live = dec_valid && !drop_q && !halt_flush;

   assign imm_sx = {{(tile_pkg::insn_w - tile_pkg::imm_w){dec_imm[tile_pkg::imm_w-1]}},
                    dec_imm};

   always_comb begin
      alu = '0;
      alu_wb = 1'b1;
      case (dec_op)
         tile_pkg::op_add:  alu = dec_rs_val + dec_rt_val;
         tile_pkg::op_sub:  alu = dec_rs_val - dec_rt_val;
         tile_pkg::op_xor:  alu = dec_rs_val ^ dec_rt_val;
         tile_pkg::op_addi: alu = dec_rs_val + imm_sx;
         tile_pkg::op_lui:  alu = {dec_imm, {(tile_pkg::insn_w - tile_pkg::imm_w){1'b0}}};
         // bnez, nop and unused codes
         default:           alu_wb = 1'b0;
      endcase
      // r0 is never a destination
      if (dec_rd == '0) begin
         alu_wb = 1'b0;
      end
   end

   // Target counts the offset in words from pc plus one
   assign branch_target = dec_pc + pc_w'(1) + dec_imm[pc_w-1:0];
   assign branch_taken = live && dec_op == tile_pkg::op_bnez && dec_rs_val != '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         v_q <= 1'b0;
         wb_q <= 1'b0;
         drop_q <= 1'b0;
      end else begin
         v_q <= live;
         wb_q <= live && alu_wb;
         // Next decode item is younger than the branch or the exit
         drop_q <= branch_taken || halt_flush;
      end
   end

   always_ff @(posedge clk) begin
      ex_pc <= dec_pc;
      ex_insn <= dec_insn;
      ex_rd <= dec_rd;
      ex_value <= alu;
   end

   // Work behind an exit nop never reaches the trace
   assign ex_valid = v_q && !halt_flush;
   assign ex_wb_en = wb_q && !halt_flush;

   // Decode has already dropped the item behind a taken branch
   a_branch_drops_decode: assert property (@(posedge clk) disable iff (!rst_n)
      branch_taken |=> !dec_valid);

endmodule

`default_nettype wire

// ==== src/insn_mem.sv ====
// Word-addressed instruction memory with a load port and a registered fetch read
`timescale 1ns/1ps
`default_nettype none

module insn_mem #(
   parameter int pc_w = 8
) (
   input  wire                          clk,
   input  wire                          imem_we,
   input  wire [pc_w-1:0]               imem_addr,
   input  wire [tile_pkg::insn_w-1:0]   imem_wdata,
   input  wire [pc_w-1:0]               fetch_addr,
   output logic [tile_pkg::insn_w-1:0]  fetch_insn
);

   // One word per pc value
   logic [tile_pkg::insn_w-1:0] mem [2**pc_w];

   // Loaded while the core is stopped
   always_ff @(posedge clk) begin
      if (imem_we) begin
         mem[imem_addr] <= imem_wdata;
      end
   end

   // Fetch data arrives one cycle after the address
   always_ff @(posedge clk) begin
      fetch_insn <= mem[fetch_addr];
   end

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
// Trace registers and the register-file write taken from them
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
   parameter int pc_w = 8
) (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                halted,
   input  wire                                ex_valid,
   input  wire [pc_w-1:0]                     ex_pc,
   input  wire [tile_pkg::insn_w-1:0]         ex_insn,
   input  wire                                ex_wb_en,
   input  wire [tile_pkg::reg_addr_w-1:0]     ex_rd,
   input  wire [tile_pkg::insn_w-1:0]         ex_value,
   output logic                               wb_en,
   output logic [tile_pkg::reg_addr_w-1:0]    wb_reg,
   output logic [tile_pkg::insn_w-1:0]        wb_data,
   output logic                               trace_valid,
   output logic [pc_w-1:0]                    trace_pc,
   output logic [tile_pkg::insn_w-1:0]        trace_insn,
   output logic                               trace_wb_en,
   output logic [tile_pkg::reg_addr_w-1:0]    trace_wb_reg,
   output logic [tile_pkg::insn_w-1:0]        trace_wb_data
);

   // Nothing retires once the tile has stopped
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         trace_valid <= 1'b0;
         trace_wb_en <= 1'b0;
      end else begin
         trace_valid <= ex_valid && !halted;
         trace_wb_en <= ex_valid && ex_wb_en && !halted;
      end
   end

   // Payload only moves with a retiring item
   always_ff @(posedge clk) begin
      if (ex_valid) begin
         trace_pc <= ex_pc;
         trace_insn <= ex_insn;
         trace_wb_reg <= ex_rd;
         trace_wb_data <= ex_value;
      end
   end

   // Register file write in the cycle of the trace entry
   assign wb_en = trace_valid && trace_wb_en;
   assign wb_reg = trace_wb_reg;
   assign wb_data = trace_wb_data;

   // Exit flush plus halted gating leaves the trace silent
   a_quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
      halted |-> !trace_valid);

endmodule

`default_nettype wire

// ==== src/run_monitor.sv ====
// Shadow r3 from the trace, nop code decode, report and putc strobes, halt
`timescale 1ns/1ps
`default_nettype none

module run_monitor (
   input  wire                                clk,
   input  wire                                rst_n,
   input  wire                                trace_valid,
   input  wire [tile_pkg::insn_w-1:0]         trace_insn,
   input  wire                                trace_wb_en,
   input  wire [tile_pkg::reg_addr_w-1:0]     trace_wb_reg,
   input  wire [tile_pkg::insn_w-1:0]         trace_wb_data,
   output logic                               report_valid,
   output logic [tile_pkg::insn_w-1:0]        report_data,
   output logic                               putc_valid,
   output logic [7:0]                         putc_char,
   output logic                               halted,
   output logic                               halt_flush
);

   logic [tile_pkg::insn_w-1:0] r3_q;
   logic is_nop;
   logic [tile_pkg::imm_w-1:0] code;

   assign is_nop = trace_valid &&
                   trace_insn[tile_pkg::op_lsb +: tile_pkg::op_w] == tile_pkg::op_nop;
   assign code = trace_insn[tile_pkg::imm_lsb +: tile_pkg::imm_w];

   // Raised with the exit entry so execute can kill what follows
   assign halt_flush = is_nop && code == tile_pkg::nop_exit && !halted;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         r3_q <= '0;
         report_valid <= 1'b0;
         putc_valid <= 1'b0;
         halted <= 1'b0;
      end else begin
         // Shadow copy tracks retired writes only
         if (trace_valid && trace_wb_en && trace_wb_reg == tile_pkg::report_reg) begin
            r3_q <= trace_wb_data;
         end
         report_valid <= is_nop && code == tile_pkg::nop_report;
         putc_valid <= is_nop && code == tile_pkg::nop_putc;
         // Sticky until reset
         if (halt_flush) begin
            halted <= 1'b1;
         end
      end
   end

   // Nops never write r3 and leave the shadow current here
   always_ff @(posedge clk) begin
      report_data <= r3_q;
      putc_char <= r3_q[7:0];
   end

endmodule

`default_nettype wire

// ==== src/tile_pkg.sv ====
// Word and register widths, opcode encodings, instruction field positions and nop codes
`default_nettype none

package tile_pkg;

   // Instruction and data word
   localparam int insn_w = 32;

   // Eight registers, r0 hardwired to zero
   localparam int reg_num = 8;
   localparam int reg_addr_w = 3;

   // Opcode lives in the top nibble
   localparam int op_w = 4;

   typedef enum logic [op_w-1:0] {
      op_add  = 4'h0,
      op_sub  = 4'h1,
      op_xor  = 4'h2,
      op_addi = 4'h3,
      op_lui  = 4'h4,
      op_bnez = 4'h5,
      op_nop  = 4'h6
   } opcode_e;

   // Low bit of each field
   localparam int op_lsb = 28;
   localparam int rd_lsb = 25;
   localparam int rs_lsb = 22;
   localparam int rt_lsb = 19;
   localparam int imm_lsb = 0;

   // Immediate, signed for addi and bnez
   localparam int imm_w = 16;

   // Codes carried in the nop immediate
   localparam logic [imm_w-1:0] nop_exit = 16'd1;
   localparam logic [imm_w-1:0] nop_report = 16'd2;
   localparam logic [imm_w-1:0] nop_putc = 16'd4;

   // Register watched by the run monitor
   localparam logic [reg_addr_w-1:0] report_reg = 3'd3;

endpackage

`default_nettype wire
